//--- testbench/vfp_cmp_patterns.txt
// funct6 _ mask _ first _ last _ expect _ vs2 _ vs1 _ expected result _ expected fflags
// vectors hold element 3 first and element 0 in the low 32 bits
04_f_0_0_1_40400000bf800000400000003f800000_40800000c00000003f00000040000000_40400000c00000003f0000003f800000_00
06_f_0_0_1_40400000bf800000400000003f800000_40800000c00000003f00000040000000_40800000bf8000004000000040000000_00
04_f_0_0_1_7fc000017fc000018000000000000000_7fc0000240a000000000000080000000_7fc0000040a000008000000080000000_00
06_f_0_0_1_7fc000017fc000018000000000000000_7fc0000240a000000000000080000000_7fc0000040a000000000000000000000_00
04_f_0_0_1_c0800000400000003f8000007f800001_c0400000400000007f80000140400000_c0800000400000003f80000040400000_10
06_5_0_0_1_40400000c00000007f8000013f800000_40800000bf8000003f80000040000000_40400000bf8000007f80000140000000_00
18_f_0_0_1_7fc0000100000000400000003f800000_3f800000800000003f8000003f800000_00000000000000000000000000000005_00
19_f_0_0_1_7fc0000100000000400000003f800000_3f800000800000003f8000003f800000_00000000000000000000000000000005_10
1b_f_0_0_1_7fc0000100000000400000003f800000_3f800000800000003f8000003f800000_00000000000000000000000000000000_10
1c_f_0_0_1_7fc0000100000000400000003f800000_3f800000800000003f8000003f800000_0000000000000000000000000000000a_00
18_f_0_0_1_7f8000013f80000080000000bf800000_3f80000040000000000000003f800000_00000000000000000000000000000002_10
1b_f_0_0_1_7f8000013f80000080000000bf800000_3f80000040000000000000003f800000_00000000000000000000000000000005_10
19_f_0_0_1_7f8000013f80000080000000bf800000_3f80000040000000000000003f800000_00000000000000000000000000000007_10
1c_f_0_0_1_7f8000013f80000080000000bf800000_3f80000040000000000000003f800000_0000000000000000000000000000000d_10
1c_3_0_0_1_7fc0000100000000400000003f800000_3f800000800000003f8000003f800000_00000000000000000000000000000002_00
1b_7_0_0_1_7fc0000100000000400000003f800000_3f800000800000003f8000003f800000_00000000000000000000000000000000_00
19_6_0_0_1_7f8000013f80000080000000bf800000_3f80000040000000000000003f800000_00000000000000000000000000000006_00
3f_f_0_0_0_7fc0000100000000400000003f800000_3f800000800000003f8000003f800000_00000000000000000000000000000000_00
05_7_1_0_0_c080000040a00000bf80000040400000_00000000000000000000000040000000_00000000000000000000000000000000_00
18_f_0_0_1_7f8000013f80000080000000bf800000_3f80000040000000000000003f800000_00000000000000000000000000000002_10
05_b_0_0_0_3f0000007f800001c00000007fc00001_000000000000000000000000c1200000_00000000000000000000000000000000_00
05_7_0_1_1_c080000080000000c04000007f800001_00000000000000000000000000000000_000000000000000000000000c0400000_10
07_d_1_0_0_4000000080000000408000003f800000_0000000000000000000000007fc00001_00000000000000000000000000000000_00
07_b_0_1_1_40200000412000007f80000140400000_00000000000000000000000000000000_00000000000000000000000040400000_10
05_1_1_1_1_3f8000003f8000003f80000080000000_00000000000000000000000000000000_00000000000000000000000080000000_00
07_0_1_1_1_40400000bf800000400000003f800000_00000000000000000000000040800000_00000000000000000000000040800000_00
00_f_0_0_0_40400000bf800000400000003f800000_40800000c00000003f00000040000000_00000000000000000000000000000000_00
04_f_0_0_1_40400000bf800000400000003f800000_40800000c00000003f00000040000000_40400000c00000003f0000003f800000_00

//--- vlog.f
common/vfp_fmt_pkg.sv
common/vfp_op_pkg.sv
src/vfp_issue.sv
lane/vfp_lane.sv
red/vfp_red.sv
src/vfp_result_pack.sv
src/vfp_cmp_unit.sv
testbench/tb_vfp_cmp_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the compare unit regression with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -sv \
   -f vlog.f \
   --top-module tb_vfp_cmp_unit \
   -Mdir obj_dir -o tb_sim

# the log decides the result, so a fatal exit must not stop the script here
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi
exit 0

//--- testbench/tb_vfp_cmp_unit.sv
// compare unit testbench
`timescale 1ns/1ps
`default_nettype none

module tb_vfp_cmp_unit;

   localparam int NUM_PATS    = 28;
   localparam int PAT_W       = 416;
   localparam int RESET_CYC   = 16;
   localparam int ACCEPT_WAIT = 200;
   localparam int DRAIN_WAIT  = 400;

   logic                     clk = 1'b0;
   logic                     reset_n;
   logic                     valid_in;
   vfp_op_pkg::funct6_t      funct6;
   vfp_fmt_pkg::vec_t        vs2;
   vfp_fmt_pkg::vec_t        vs1;
   vfp_fmt_pkg::elem_mask_t  vm;
   logic                     first;
   logic                     last;
   logic                     ready_in;
   logic                     ready_out;
   logic                     valid_out;
   vfp_fmt_pkg::vec_t        result;
   vfp_fmt_pkg::fflags_t     fflags;

   logic [PAT_W-1:0] patterns [NUM_PATS];
   logic [132:0]     exp_q [$]; // expected result over flags
   int               sent_cnt;

   vfp_cmp_unit dut0 (
      .i_clk     (clk),
      .i_reset_n (reset_n),
      .i_valid   (valid_in),
      .i_funct6  (funct6),
      .i_vs2     (vs2),
      .i_vs1     (vs1),
      .i_vm      (vm),
      .i_first   (first),
      .i_last    (last),
      .i_ready   (ready_in),
      .o_ready   (ready_out),
      .o_valid   (valid_out),
      .o_result  (result),
      .o_fflags  (fflags)
   );

   always #20 clk = ~clk;

   task automatic stop_on_error();
      $display("Regression failed");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic compare_field(input string name, input logic [127:0] got,
                                input logic [127:0] expv);
      assert (got === expv) else begin
         $display("CHECK FAILED %s expected %h got %h", name, expv, got);
         stop_on_error();
      end
   endtask

   // back-pressure in random stretches
   initial begin : ready_gen
      int          stretch;
      logic        level;
      ready_in = 1'b0;
      stretch  = 0;
      void'($urandom(32'h3ceab628));
      forever begin
         @(negedge clk);
         if (stretch == 0) begin
            level   = ($urandom % 3) != 0;
            stretch = 1 + ($urandom % 6);
         end
         ready_in = level;
         stretch--;
      end
   end

   // sampled just after the falling edge
   // handshake lands on the next rising edge
   initial begin : out_check
      logic [132:0] expv;
      forever begin
         @(negedge clk);
         #1;
         if (reset_n && valid_out && ready_in) begin
            assert (exp_q.size() > 0) else begin
               $display("output beat seen with no result pending");
               stop_on_error();
            end
            expv = exp_q.pop_front();
            compare_field("o_result", result, expv[132:5]);
            compare_field("o_fflags", {123'd0, fflags}, {123'd0, expv[4:0]});
         end
      end
   end

   initial begin : drive
      logic [PAT_W-1:0] pat;
      int               wait_cyc;
      reset_n  = 1'b0;
      valid_in = 1'b0;
      funct6   = '0;
      vs2      = '0;
      vs1      = '0;
      vm       = '0;
      first    = 1'b0;
      last     = 1'b0;
      sent_cnt = 0;
      $readmemh("testbench/vfp_cmp_patterns.txt", patterns);
      repeat (RESET_CYC) @(negedge clk);
      reset_n = 1'b1;

      for (int p = 0; p < NUM_PATS; p++) begin
         pat = patterns[p];
         @(negedge clk);
         valid_in = 1'b1;
         funct6   = pat[413:408];
         vm       = pat[407:404];
         first    = pat[400];
         last     = pat[396];
         vs2      = pat[391:264];
         vs1      = pat[263:136];
         #1;
         wait_cyc = 0;
         while (!ready_out) begin
            wait_cyc++;
            assert (wait_cyc < ACCEPT_WAIT) else begin
               $display("beat %0d was never accepted, o_ready stayed low", p);
               stop_on_error();
            end
            @(negedge clk);
            #1;
         end
         if (pat[392]) begin
            exp_q.push_back({pat[135:8], pat[4:0]});
            sent_cnt++;
         end
         @(posedge clk); // beat taken here
      end
      @(negedge clk);
      valid_in = 1'b0;

      wait_cyc = 0;
      while (exp_q.size() != 0 && wait_cyc < DRAIN_WAIT) begin
         @(negedge clk);
         wait_cyc++;
      end
      repeat (8) @(negedge clk); // room for a stray output to show up

      if (exp_q.size() == 0) begin
         $display("Regression passed");
         $finish;
      end else begin
         $display("results missing at the end, %0d of %0d still pending",
                  exp_q.size(), sent_cnt);
         stop_on_error();
      end
   end

endmodule

`default_nettype wire

//--- src/vfp_cmp_unit.sv
// vector f32 compare and select unit
`timescale 1ns/1ps
`default_nettype none

module vfp_cmp_unit (
   input  wire                      i_clk,
   input  wire                      i_reset_n,
   input  logic                     i_valid,
   input  vfp_op_pkg::funct6_t      i_funct6,
   input  vfp_fmt_pkg::vec_t        i_vs2,
   input  vfp_fmt_pkg::vec_t        i_vs1,
   input  vfp_fmt_pkg::elem_mask_t  i_vm,
   input  logic                     i_first,
   input  logic                     i_last,
   input  logic                     i_ready,
   output logic                     o_ready,
   output logic                     o_valid,
   output vfp_fmt_pkg::vec_t        o_result,
   output vfp_fmt_pkg::fflags_t     o_fflags
);

   localparam int EPL = vfp_fmt_pkg::ELEMS_PER_LANE;
   localparam int LW  = vfp_fmt_pkg::LANE_W;

   logic                      stall;
   logic                      s1_valid;
   vfp_op_pkg::vfp_op_e       s1_op;
   vfp_fmt_pkg::elem_mask_t   s1_vm;
   vfp_fmt_pkg::vec_t         s1_a;
   vfp_fmt_pkg::vec_t         s1_b;
   logic                      s1_first;
   logic                      s1_last;
   wire vfp_fmt_pkg::vec_t    lane_res;
   wire vfp_fmt_pkg::elem_mask_t lane_cmp;
   vfp_fmt_pkg::fflags_t      lane_exc [vfp_fmt_pkg::NUM_LANES];
   vfp_fmt_pkg::f32_t         red_res;
   vfp_fmt_pkg::fflags_t      red_exc;

   vfp_issue u_issue (
      .i_clk      (i_clk),
      .i_reset_n  (i_reset_n),
      .i_valid    (i_valid),
      .i_funct6   (i_funct6),
      .i_vs2      (i_vs2),
      .i_vs1      (i_vs1),
      .i_vm       (i_vm),
      .i_first    (i_first),
      .i_last     (i_last),
      .i_stall    (stall),
      .o_ready    (o_ready),
      .o_s1_valid (s1_valid),
      .o_s1_op    (s1_op),
      .o_s1_vm    (s1_vm),
      .o_s1_a     (s1_a),
      .o_s1_b     (s1_b),
      .o_s1_first (s1_first),
      .o_s1_last  (s1_last)
   );

   for (genvar l = 0; l < vfp_fmt_pkg::NUM_LANES; l++) begin : g_lane
      vfp_lane u_lane (
         .i_clk     (i_clk),
         .i_reset_n (i_reset_n),
         .i_stall   (stall),
         .i_valid   (s1_valid),
         .i_op      (s1_op),
         .i_vm      (s1_vm[l*EPL +: EPL]),
         .i_a       (s1_a[l*LW +: LW]),
         .i_b       (s1_b[l*LW +: LW]),
         .o_res     (lane_res[l*LW +: LW]),
         .o_cmp     (lane_cmp[l*EPL +: EPL]),
         .o_exc     (lane_exc[l])
      );
   end

   vfp_red u_red (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_stall   (stall),
      .i_valid   (s1_valid),
      .i_op      (s1_op),
      .i_vm      (s1_vm),
      .i_a       (s1_a),
      .i_seed    (s1_b[vfp_fmt_pkg::F32_W-1:0]), // element 0 of vs1
      .i_first   (s1_first),
      .i_last    (s1_last),
      .o_res     (red_res),
      .o_exc     (red_exc)
   );

   vfp_result_pack u_pack (
      .i_clk       (i_clk),
      .i_reset_n   (i_reset_n),
      .i_ready     (i_ready),
      .i_s1_valid  (s1_valid),
      .i_s1_op     (s1_op),
      .i_s1_last   (s1_last),
      .i_lane_res  (lane_res),
      .i_lane_cmp  (lane_cmp),
      .i_lane0_exc (lane_exc[0]),
      .i_lane1_exc (lane_exc[1]),
      .i_red_res   (red_res),
      .i_red_exc   (red_exc),
      .o_stall     (stall),
      .o_valid     (o_valid),
      .o_result    (o_result),
      .o_fflags    (o_fflags)
   );

endmodule

`default_nettype wire

//--- src/vfp_result_pack.sv
// stage 2 control and result packing
`timescale 1ns/1ps
`default_nettype none

module vfp_result_pack (
   input  wire                      i_clk,
   input  wire                      i_reset_n,
   input  logic                     i_ready,
   input  logic                     i_s1_valid,
   input  vfp_op_pkg::vfp_op_e      i_s1_op,
   input  logic                     i_s1_last,
   input  vfp_fmt_pkg::vec_t        i_lane_res,
   input  vfp_fmt_pkg::elem_mask_t  i_lane_cmp,
   input  vfp_fmt_pkg::fflags_t     i_lane0_exc,
   input  vfp_fmt_pkg::fflags_t     i_lane1_exc,
   input  vfp_fmt_pkg::f32_t        i_red_res,
   input  vfp_fmt_pkg::fflags_t     i_red_exc,
   output logic                     o_stall,
   output logic                     o_valid,
   output vfp_fmt_pkg::vec_t        o_result,
   output vfp_fmt_pkg::fflags_t     o_fflags
);

   vfp_op_pkg::vfp_op_e s2_op;
   logic                is_red;
   logic                s2_valid_d;
   logic                s2_is_red;

   assign o_stall = o_valid && !i_ready;

   assign is_red     = (i_s1_op == vfp_op_pkg::op_redmin) || (i_s1_op == vfp_op_pkg::op_redmax);
   assign s2_valid_d = i_s1_valid && (is_red ? i_s1_last : (i_s1_op != vfp_op_pkg::op_illegal));

   always_ff @(posedge i_clk, negedge i_reset_n) begin
      if (!i_reset_n) begin
         o_valid <= 1'b0;
         s2_op   <= vfp_op_pkg::op_illegal;
      end else if (!o_stall) begin
         o_valid <= s2_valid_d;
         s2_op   <= i_s1_op;
      end
   end

   assign s2_is_red = (s2_op == vfp_op_pkg::op_redmin) || (s2_op == vfp_op_pkg::op_redmax);

   always_comb begin
      o_result = '0;
      case (s2_op)
         vfp_op_pkg::op_min,
         vfp_op_pkg::op_max:    o_result = i_lane_res;
         vfp_op_pkg::op_eq,
         vfp_op_pkg::op_le,
         vfp_op_pkg::op_lt,
         vfp_op_pkg::op_ne:     o_result[vfp_fmt_pkg::ELEMS-1:0] = i_lane_cmp; // mask bits
         vfp_op_pkg::op_redmin,
         vfp_op_pkg::op_redmax: o_result[vfp_fmt_pkg::F32_W-1:0] = i_red_res;
         default: ;
      endcase
   end

   assign o_fflags = s2_is_red ? i_red_exc : (i_lane0_exc | i_lane1_exc);

endmodule

`default_nettype wire

//--- red/vfp_red.sv
// ordered min/max reduction
`timescale 1ns/1ps
`default_nettype none

module vfp_red (
   input  wire                      i_clk,
   input  wire                      i_reset_n,
   input  logic                     i_stall,
   input  logic                     i_valid,
   input  vfp_op_pkg::vfp_op_e      i_op,
   input  vfp_fmt_pkg::elem_mask_t  i_vm,
   input  vfp_fmt_pkg::vec_t        i_a,
   input  vfp_fmt_pkg::f32_t        i_seed,
   input  logic                     i_first,
   input  logic                     i_last,
   output vfp_fmt_pkg::f32_t        o_res,
   output vfp_fmt_pkg::fflags_t     o_exc
);

   vfp_op_pkg::red_state_e state_q;
   vfp_fmt_pkg::f32_t      acc_d;
   vfp_fmt_pkg::fflags_t   exc_d;
   logic                   nv_d;
   logic                   red_beat;
   logic                   is_max;
   logic                   restart;

   assign red_beat = i_valid && !i_stall &&
                     (i_op == vfp_op_pkg::op_redmin || i_op == vfp_op_pkg::op_redmax);
   assign is_max   = i_op == vfp_op_pkg::op_redmax;
   assign restart  = i_first || (state_q == vfp_op_pkg::red_idle);

   // fold elements 0..3 in order
   always_comb begin
      acc_d = restart ? i_seed : o_res;
      nv_d  = restart ? vfp_fmt_pkg::f32_is_snan(i_seed) : o_exc[vfp_fmt_pkg::FFLAG_NV];
      for (int e = 0; e < vfp_fmt_pkg::ELEMS; e++) begin
         if (i_vm[e]) begin
            nv_d  = nv_d | vfp_fmt_pkg::f32_is_snan(i_a[e*vfp_fmt_pkg::F32_W +: vfp_fmt_pkg::F32_W]);
            acc_d = vfp_fmt_pkg::f32_minmax(acc_d,
                                            i_a[e*vfp_fmt_pkg::F32_W +: vfp_fmt_pkg::F32_W],
                                            is_max);
         end
      end
   end

   always_comb begin
      exc_d                        = '0;
      exc_d[vfp_fmt_pkg::FFLAG_NV] = nv_d;
   end

   always_ff @(posedge i_clk, negedge i_reset_n) begin
      if (!i_reset_n) begin
         state_q <= vfp_op_pkg::red_idle;
      end else if (red_beat) begin
         state_q <= i_last ? vfp_op_pkg::red_idle : vfp_op_pkg::red_accum;
      end
   end

   // accumulator doubles as the stage 2 result
   always_ff @(posedge i_clk) begin
      if (red_beat) begin
         o_res <= acc_d;
         o_exc <= exc_d;
      end
   end

endmodule

`default_nettype wire

//--- lane/vfp_lane.sv
// f32 compare and min/max lane
`timescale 1ns/1ps
`default_nettype none

module vfp_lane (
   input  wire                                        i_clk,
   input  wire                                        i_reset_n,
   input  logic                                       i_stall,
   input  logic                                       i_valid,
   input  vfp_op_pkg::vfp_op_e                        i_op,
   input  logic [vfp_fmt_pkg::ELEMS_PER_LANE-1:0]     i_vm,
   input  vfp_fmt_pkg::lane_t                         i_a,
   input  vfp_fmt_pkg::lane_t                         i_b,
   output vfp_fmt_pkg::lane_t                         o_res,
   output logic [vfp_fmt_pkg::ELEMS_PER_LANE-1:0]     o_cmp,
   output vfp_fmt_pkg::fflags_t                       o_exc
);

   wire vfp_fmt_pkg::lane_t                       res_d;
   wire [vfp_fmt_pkg::ELEMS_PER_LANE-1:0]         cmp_d;
   wire [vfp_fmt_pkg::ELEMS_PER_LANE-1:0]         nv_d;
   vfp_fmt_pkg::fflags_t                          exc_d;

   for (genvar e = 0; e < vfp_fmt_pkg::ELEMS_PER_LANE; e++) begin : g_elem
      vfp_fmt_pkg::f32_t a;
      vfp_fmt_pkg::f32_t b;
      vfp_fmt_pkg::f32_t res;
      logic              any_nan;
      logic              any_snan;
      logic              is_eq;
      logic              is_lt;
      logic              cmp;
      logic              nv;

      assign a        = i_a[e*vfp_fmt_pkg::F32_W +: vfp_fmt_pkg::F32_W];
      assign b        = i_b[e*vfp_fmt_pkg::F32_W +: vfp_fmt_pkg::F32_W];
      assign any_nan  = vfp_fmt_pkg::f32_is_nan(a) || vfp_fmt_pkg::f32_is_nan(b);
      assign any_snan = vfp_fmt_pkg::f32_is_snan(a) || vfp_fmt_pkg::f32_is_snan(b);
      // +0 and -0 compare equal here
      assign is_eq    = (a == b) || (vfp_fmt_pkg::f32_is_zero(a) && vfp_fmt_pkg::f32_is_zero(b));
      assign is_lt    = vfp_fmt_pkg::f32_lt_tot(a, b) && !is_eq;

      always_comb begin
         res = a; // masked-off elements pass a
         cmp = 1'b0;
         nv  = 1'b0;
         if (i_vm[e]) begin
            case (i_op)
               vfp_op_pkg::op_min: begin
                  res = vfp_fmt_pkg::f32_minmax(a, b, 1'b0);
                  nv  = any_snan;
               end
               vfp_op_pkg::op_max: begin
                  res = vfp_fmt_pkg::f32_minmax(a, b, 1'b1);
                  nv  = any_snan;
               end
               vfp_op_pkg::op_eq: begin
                  cmp = !any_nan && is_eq;
                  nv  = any_snan;
               end
               vfp_op_pkg::op_ne: begin
                  cmp = any_nan || !is_eq;
                  nv  = any_snan;
               end
               vfp_op_pkg::op_lt: begin
                  cmp = !any_nan && is_lt;
                  nv  = any_nan; // signaling compare
               end
               vfp_op_pkg::op_le: begin
                  cmp = !any_nan && (is_lt || is_eq);
                  nv  = any_nan;
               end
               default: ;
            endcase
         end
      end

      assign res_d[e*vfp_fmt_pkg::F32_W +: vfp_fmt_pkg::F32_W] = res;
      assign cmp_d[e] = cmp;
      assign nv_d[e]  = nv;
   end

   always_comb begin
      exc_d                        = '0;
      exc_d[vfp_fmt_pkg::FFLAG_NV] = |nv_d;
   end

   always_ff @(posedge i_clk, negedge i_reset_n) begin
      if (!i_reset_n) begin
         o_cmp <= '0;
         o_exc <= '0;
      end else if (i_valid && !i_stall) begin
         o_cmp <= cmp_d;
         o_exc <= exc_d;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_valid && !i_stall) begin
         o_res <= res_d;
      end
   end

endmodule

`default_nettype wire

//--- src/vfp_issue.sv
// issue stage and funct6 decode
`timescale 1ns/1ps
`default_nettype none

module vfp_issue (
   input  wire                      i_clk,
   input  wire                      i_reset_n,
   input  logic                     i_valid,
   input  vfp_op_pkg::funct6_t      i_funct6,
   input  vfp_fmt_pkg::vec_t        i_vs2,
   input  vfp_fmt_pkg::vec_t        i_vs1,
   input  vfp_fmt_pkg::elem_mask_t  i_vm,
   input  logic                     i_first,
   input  logic                     i_last,
   input  logic                     i_stall,
   output logic                     o_ready,
   output logic                     o_s1_valid,
   output vfp_op_pkg::vfp_op_e      o_s1_op,
   output vfp_fmt_pkg::elem_mask_t  o_s1_vm,
   output vfp_fmt_pkg::vec_t        o_s1_a,
   output vfp_fmt_pkg::vec_t        o_s1_b,
   output logic                     o_s1_first,
   output logic                     o_s1_last
);

   vfp_op_pkg::vfp_op_e op_d;
   logic                accept;

   assign o_ready = !i_stall;
   assign accept  = i_valid && o_ready;

   always_comb begin
      case (i_funct6)
         vfp_op_pkg::F6_VFMIN:    op_d = vfp_op_pkg::op_min;
         vfp_op_pkg::F6_VFMAX:    op_d = vfp_op_pkg::op_max;
         vfp_op_pkg::F6_VMFEQ:    op_d = vfp_op_pkg::op_eq;
         vfp_op_pkg::F6_VMFLE:    op_d = vfp_op_pkg::op_le;
         vfp_op_pkg::F6_VMFLT:    op_d = vfp_op_pkg::op_lt;
         vfp_op_pkg::F6_VMFNE:    op_d = vfp_op_pkg::op_ne;
         vfp_op_pkg::F6_VFREDMIN: op_d = vfp_op_pkg::op_redmin;
         vfp_op_pkg::F6_VFREDMAX: op_d = vfp_op_pkg::op_redmax;
         default:                 op_d = vfp_op_pkg::op_illegal; // dropped downstream
      endcase
   end

   always_ff @(posedge i_clk, negedge i_reset_n) begin
      if (!i_reset_n) begin
         o_s1_valid <= 1'b0;
      end else if (!i_stall) begin
         o_s1_valid <= i_valid;
      end
   end

   // stage 1 payload
   always_ff @(posedge i_clk) begin
      if (accept) begin
         o_s1_op    <= op_d;
         o_s1_vm    <= i_vm;
         o_s1_a     <= i_vs2;
         o_s1_b     <= i_vs1;
         o_s1_first <= i_first;
         o_s1_last  <= i_last;
      end
   end

endmodule

`default_nettype wire

//--- common/vfp_op_pkg.sv
// compare unit opcodes and states
`default_nettype none

package vfp_op_pkg;

   localparam int FUNCT6_W = 6;

   typedef logic [FUNCT6_W-1:0] funct6_t;

   localparam funct6_t F6_VFMIN    = 6'b000100;
   localparam funct6_t F6_VFREDMIN = 6'b000101;
   localparam funct6_t F6_VFMAX    = 6'b000110;
   localparam funct6_t F6_VFREDMAX = 6'b000111;
   localparam funct6_t F6_VMFEQ    = 6'b011000;
   localparam funct6_t F6_VMFLE    = 6'b011001;
   localparam funct6_t F6_VMFLT    = 6'b011011;
   localparam funct6_t F6_VMFNE    = 6'b011100;

   // nine codes, so one bit more than the plain ops need
   typedef enum logic [3:0] {
      op_min,
      op_max,
      op_eq,
      op_le,
      op_lt,
      op_ne,
      op_redmin,
      op_redmax,
      op_illegal
   } vfp_op_e;

   typedef enum logic {
      red_idle,
      red_accum
   } red_state_e;

endpackage

`default_nettype wire

//--- common/vfp_fmt_pkg.sv
// f32 format and lane geometry
`default_nettype none

package vfp_fmt_pkg;

   localparam int NUM_LANES      = 2;
   localparam int LANE_W         = 64;
   localparam int F32_W          = 32;
   localparam int ELEMS_PER_LANE = LANE_W / F32_W;
   localparam int ELEMS          = NUM_LANES * ELEMS_PER_LANE;
   localparam int VEC_W          = NUM_LANES * LANE_W;

   typedef logic [F32_W-1:0]  f32_t;
   typedef logic [LANE_W-1:0] lane_t;
   typedef logic [VEC_W-1:0]  vec_t;
   typedef logic [ELEMS-1:0]  elem_mask_t;
   typedef logic [4:0]        fflags_t;

   // accrued flag bit positions
   localparam int FFLAG_NV = 4;
   localparam int FFLAG_DZ = 3;
   localparam int FFLAG_OF = 2;
   localparam int FFLAG_UF = 1;
   localparam int FFLAG_NX = 0;

   localparam f32_t F32_CANON_NAN = 32'h7fc0_0000;

   function automatic logic f32_is_nan(f32_t f);
      return (f[30:23] == 8'hff) && (f[22:0] != 23'd0);
   endfunction

   function automatic logic f32_is_snan(f32_t f);
      return f32_is_nan(f) && !f[22]; // quiet bit clear
   endfunction

   function automatic logic f32_is_zero(f32_t f);
      return f[30:0] == 31'd0;
   endfunction

   // sign-magnitude order, -0 sorts below +0
   function automatic logic f32_lt_tot(f32_t a, f32_t b);
      if (a[31] != b[31])
         return a[31];
      return a[31] ? (a[30:0] > b[30:0]) : (a[30:0] < b[30:0]);
   endfunction

   function automatic f32_t f32_minmax(f32_t a, f32_t b, logic is_max);
      if (f32_is_nan(a) && f32_is_nan(b))
         return F32_CANON_NAN;
      if (f32_is_nan(a))
         return b;
      if (f32_is_nan(b))
         return a;
      if (is_max)
         return f32_lt_tot(a, b) ? b : a;
      return f32_lt_tot(b, a) ? b : a;
   endfunction

endpackage

`default_nettype wire
